// File: src/rx_config.svh
`ifndef RX_CONFIG_SVH
`define RX_CONFIG_SVH

`define RX_BYTE_W            8
`define RX_OFFSET_W          6   // byte offset counter, saturates at 63

// byte offsets from the first byte of the ethernet frame
`define RX_OFS_DST_MAC       0
`define RX_OFS_SRC_MAC       6
`define RX_OFS_ETHERTYPE     12
`define RX_OFS_IP_VER_IHL    14
`define RX_OFS_IP_PROTO      23
`define RX_OFS_IP_SRC        26
`define RX_OFS_IP_DST        30
`define RX_OFS_UDP_DST_PORT  36
`define RX_OFS_UDP_LEN       38
`define RX_OFS_ARP_OPER      20
`define RX_OFS_ARP_SPA       28
`define RX_OFS_ARP_TPA       38

`define RX_MIN_FRAME_LEN     42  // eth + ip + udp headers, also covers the arp body

`define RX_ETHERTYPE_IPV4    16'h0800
`define RX_ETHERTYPE_ARP     16'h0806
`define RX_IP_PROTO_UDP      8'd17
`define RX_IPV4_VER_IHL      8'h45   // version 4, no options
`define RX_ARP_OPER_REQUEST  16'd1

`endif

// File: src/eth_pkg.sv
`include "rx_config.svh"

package eth_pkg;

    // raw protocol fields as they sit on the wire, msb first

    typedef logic [`RX_BYTE_W-1:0] byte_t;

    typedef logic [47:0] mac_t;

    typedef logic [31:0] ip_t;

    // udp port, also used for other 16-bit words such as lengths
    typedef logic [15:0] port_t;

    typedef logic [15:0] ethertype_t;

    typedef logic [7:0] ip_proto_t;

endpackage

// File: src/rx_pkg.sv
`include "rx_config.svh"

package rx_pkg;

    typedef logic [`RX_OFFSET_W-1:0] offset_t;

    typedef struct packed {
        eth_pkg::mac_t       dst_mac;
        eth_pkg::mac_t       src_mac;
        eth_pkg::ethertype_t ethertype;
        eth_pkg::byte_t      ver_ihl;
        eth_pkg::ip_proto_t  ip_proto;
        eth_pkg::ip_t        ip_src;
        eth_pkg::ip_t        ip_dst;
        eth_pkg::port_t      udp_dst_port;
        eth_pkg::port_t      udp_len;
        eth_pkg::port_t      arp_oper;
        eth_pkg::ip_t        arp_spa;
        eth_pkg::ip_t        arp_tpa;   // ip and arp fields overlap, both are captured
    } header_fields_t;

    typedef struct packed {
        header_fields_t hdr;
        logic           error;
        offset_t        last_ofs;   // offset of the eop byte
    } parsed_packet_t;

    typedef struct packed {
        eth_pkg::mac_t mac;
        eth_pkg::ip_t  ip;
    } arp_reply_t;

    typedef struct packed {
        eth_pkg::port_t length;
        eth_pkg::ip_t   ip;
        eth_pkg::mac_t  mac;
    } udp_status_t;

endpackage

// File: src/rx_beat_if.sv
`timescale 1ns/10ps

// one registered stream byte tagged with its position in the frame
interface rx_beat_if;

    eth_pkg::byte_t  data;
    logic            valid;
    logic            sop;
    logic            eop;
    logic            error;
    rx_pkg::offset_t offset;

    modport src (output data, valid, sop, eop, error, offset);

    modport dst (input data, valid, sop, eop, error, offset);

endinterface

// File: src/header_field_capture.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module header_field_capture #(
    parameter type field_t   = eth_pkg::byte_t,
    parameter int  FIELD_OFS = 0
) (
    input  logic   rx_xcvr_clk,
    input  logic   rx_sync_rst,
    rx_beat_if.dst beat,
    output field_t field
);

    localparam int FIELD_W     = $bits(field_t);
    localparam int FIELD_BYTES = FIELD_W / `RX_BYTE_W;
    localparam rx_pkg::offset_t OFS_FIRST = rx_pkg::offset_t'(FIELD_OFS);
    localparam rx_pkg::offset_t OFS_LAST  = rx_pkg::offset_t'(FIELD_OFS + FIELD_BYTES - 1);

    logic                            in_window;
    logic [FIELD_W+`RX_BYTE_W-1:0]   shifted;

    assign in_window = beat.valid && (beat.offset >= OFS_FIRST) && (beat.offset <= OFS_LAST);
    assign shifted   = {field, beat.data};   // network order, first byte ends up on top

    always_ff @(posedge rx_xcvr_clk)
    begin
        if (rx_sync_rst)
            field <= '0;
        else if (in_window)
            field <= shifted[FIELD_W-1:0];
    end

endmodule

// File: src/rx_byte_tracker.sv
`timescale 1ns/10ps

module rx_byte_tracker (
    input  logic           rx_xcvr_clk,
    input  logic           rx_sync_rst,
    input  eth_pkg::byte_t st_rx_data,
    input  logic           st_rx_valid,
    input  logic           st_rx_startofpacket,
    input  logic           st_rx_endofpacket,
    input  logic           st_rx_error,
    rx_beat_if.src         beat
);

    logic            in_frame_q;
    logic            in_frame;
    logic            take;
    rx_pkg::offset_t next_ofs;

    assign in_frame = in_frame_q | st_rx_startofpacket;   // sop opens the frame at once
    assign take     = st_rx_valid & in_frame;
    assign next_ofs = (beat.offset == '1) ? beat.offset : beat.offset + 1'b1;

    always_ff @(posedge rx_xcvr_clk)
    begin
        if (rx_sync_rst)
        begin
            in_frame_q <= 1'b0;
            beat.valid <= 1'b0;
        end
        else
        begin
            beat.valid <= take;
            if (take)
                in_frame_q <= ~st_rx_endofpacket;
        end
    end

    // beat payload only moves on accepted bytes
    always_ff @(posedge rx_xcvr_clk)
    begin
        if (take)
        begin
            beat.data   <= st_rx_data;
            beat.sop    <= st_rx_startofpacket;
            beat.eop    <= st_rx_endofpacket;
            beat.error  <= st_rx_error;
            beat.offset <= st_rx_startofpacket ? '0 : next_ofs;
        end
    end

endmodule

// File: src/rx_header_parse.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module rx_header_parse (
    input  logic                   rx_xcvr_clk,
    input  logic                   rx_sync_rst,
    rx_beat_if.dst                 beat,
    output logic                   pkt_done,
    output rx_pkg::parsed_packet_t pkt
);

    rx_pkg::header_fields_t fields;
    logic                   err_q;
    logic                   done_q;
    rx_pkg::offset_t        last_ofs_q;
    logic                   eop_beat;

    assign eop_beat = beat.valid & beat.eop;

    header_field_capture #(.field_t(eth_pkg::mac_t), .FIELD_OFS(`RX_OFS_DST_MAC)) i_dst_mac (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.dst_mac));

    header_field_capture #(.field_t(eth_pkg::mac_t), .FIELD_OFS(`RX_OFS_SRC_MAC)) i_src_mac (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.src_mac));

    header_field_capture #(
        .field_t(eth_pkg::ethertype_t), .FIELD_OFS(`RX_OFS_ETHERTYPE)) i_ethertype (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.ethertype));

    header_field_capture #(.field_t(eth_pkg::byte_t), .FIELD_OFS(`RX_OFS_IP_VER_IHL)) i_ver_ihl (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.ver_ihl));

    header_field_capture #(.field_t(eth_pkg::ip_proto_t), .FIELD_OFS(`RX_OFS_IP_PROTO)) i_proto (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.ip_proto));

    header_field_capture #(.field_t(eth_pkg::ip_t), .FIELD_OFS(`RX_OFS_IP_SRC)) i_ip_src (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.ip_src));

    header_field_capture #(.field_t(eth_pkg::ip_t), .FIELD_OFS(`RX_OFS_IP_DST)) i_ip_dst (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.ip_dst));

    header_field_capture #(.field_t(eth_pkg::port_t), .FIELD_OFS(`RX_OFS_UDP_DST_PORT)) i_port (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.udp_dst_port));

    header_field_capture #(.field_t(eth_pkg::port_t), .FIELD_OFS(`RX_OFS_UDP_LEN)) i_udp_len (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.udp_len));

    header_field_capture #(.field_t(eth_pkg::port_t), .FIELD_OFS(`RX_OFS_ARP_OPER)) i_arp_oper (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.arp_oper));

    header_field_capture #(.field_t(eth_pkg::ip_t), .FIELD_OFS(`RX_OFS_ARP_SPA)) i_arp_spa (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.arp_spa));

    header_field_capture #(.field_t(eth_pkg::ip_t), .FIELD_OFS(`RX_OFS_ARP_TPA)) i_arp_tpa (
        .rx_xcvr_clk(rx_xcvr_clk), .rx_sync_rst(rx_sync_rst), .beat(beat),
        .field(fields.arp_tpa));

    always_ff @(posedge rx_xcvr_clk)
    begin
        if (rx_sync_rst)
        begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
        end
        else
        begin
            done_q <= eop_beat;
            if (beat.valid)
                err_q <= beat.sop ? beat.error : (err_q | beat.error);   // sticky per packet
        end
    end

    always_ff @(posedge rx_xcvr_clk)
    begin
        if (eop_beat)
            last_ofs_q <= beat.offset;
    end

    // the capture registers took the eop byte on the same edge as done_q,
    // and the earliest next sop byte lands one edge later, so the fields
    // stay frozen for exactly the pkt_done cycle
    assign pkt_done     = done_q;
    assign pkt.hdr      = fields;
    assign pkt.error    = err_q;
    assign pkt.last_ofs = last_ofs_q;

endmodule

// File: src/rx_packet_classifier.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module rx_packet_classifier (
    input  logic                   rx_xcvr_clk,
    input  logic                   rx_sync_rst,
    input  logic                   pkt_done,
    input  rx_pkg::parsed_packet_t pkt,
    input  eth_pkg::mac_t          local_mac,
    input  eth_pkg::ip_t           local_ip,
    input  eth_pkg::port_t         local_stream_1_port,
    input  eth_pkg::port_t         local_stream_2_port,
    input  logic                   tx_busy,
    output logic                   arp_reply_valid,
    output rx_pkg::arp_reply_t     arp_reply,
    output logic                   udp_status_valid,
    output rx_pkg::udp_status_t    udp_status,
    output logic                   select_udp_port
);

    logic common_ok;
    logic port_1_hit;
    logic port_2_hit;
    logic arp_hit;
    logic udp_hit;

    // mac filter, broadcast always passes
    assign common_ok = !pkt.error
                    && (pkt.last_ofs >= rx_pkg::offset_t'(`RX_MIN_FRAME_LEN - 1))
                    && ((pkt.hdr.dst_mac == local_mac) || (pkt.hdr.dst_mac == '1));

    assign port_1_hit = (pkt.hdr.udp_dst_port == local_stream_1_port);
    assign port_2_hit = (pkt.hdr.udp_dst_port == local_stream_2_port);

    assign arp_hit = common_ok
                  && (pkt.hdr.ethertype == `RX_ETHERTYPE_ARP)
                  && (pkt.hdr.arp_oper == `RX_ARP_OPER_REQUEST)
                  && (pkt.hdr.arp_tpa == local_ip)
                  && !tx_busy;   // no reply slot while tx is busy

    assign udp_hit = common_ok
                  && (pkt.hdr.ethertype == `RX_ETHERTYPE_IPV4)
                  && (pkt.hdr.ver_ihl == `RX_IPV4_VER_IHL)   // options not supported
                  && (pkt.hdr.ip_proto == `RX_IP_PROTO_UDP)
                  && (pkt.hdr.ip_dst == local_ip)
                  && (port_1_hit || port_2_hit)
                  && (pkt.hdr.udp_len != '0);

    always_ff @(posedge rx_xcvr_clk)
    begin
        if (rx_sync_rst)
        begin
            arp_reply_valid  <= 1'b0;
            udp_status_valid <= 1'b0;
            select_udp_port  <= 1'b0;
        end
        else
        begin
            arp_reply_valid  <= pkt_done & arp_hit;
            udp_status_valid <= pkt_done & udp_hit;
            if (pkt_done && udp_hit)
                select_udp_port <= port_2_hit;   // stream 2 wins if both ports match
        end
    end

    always_ff @(posedge rx_xcvr_clk)
    begin
        if (pkt_done && arp_hit)
        begin
            arp_reply.mac <= pkt.hdr.src_mac;
            arp_reply.ip  <= pkt.hdr.arp_spa;
        end
        if (pkt_done && udp_hit)
        begin
            udp_status.length <= pkt.hdr.udp_len;
            udp_status.ip     <= pkt.hdr.ip_src;
            udp_status.mac    <= pkt.hdr.src_mac;
        end
    end

endmodule

// File: src/rx_manager.sv
`timescale 1ns/10ps

module rx_manager (
    input  logic           rx_xcvr_clk,
    input  logic           rx_sync_rst,
    input  eth_pkg::byte_t st_rx_data,
    input  logic           st_rx_valid,
    input  logic           st_rx_startofpacket,
    input  logic           st_rx_endofpacket,
    input  logic           st_rx_error,
    output logic           st_rx_ready,
    input  eth_pkg::mac_t  local_mac,
    input  eth_pkg::ip_t   local_ip,
    input  eth_pkg::port_t local_stream_1_port,
    input  eth_pkg::port_t local_stream_2_port,
    input  logic           tx_busy,
    output logic           arp_to_tx_valid,
    output eth_pkg::mac_t  arp_to_tx_mac,
    output eth_pkg::ip_t   arp_to_tx_ip,
    output logic           udp_status_valid,
    output eth_pkg::port_t udp_status_length,
    output eth_pkg::ip_t   udp_status_ip,
    output eth_pkg::mac_t  udp_status_mac,
    output logic           select_udp_port
);

    rx_beat_if              beat_if ();
    logic                   pkt_done;
    rx_pkg::parsed_packet_t pkt;
    rx_pkg::arp_reply_t     arp_reply;
    rx_pkg::udp_status_t    udp_status;

    assign st_rx_ready = 1'b1;   // every byte is consumed, no back-pressure

    rx_byte_tracker i_tracker (
        .rx_xcvr_clk         (rx_xcvr_clk),
        .rx_sync_rst         (rx_sync_rst),
        .st_rx_data          (st_rx_data),
        .st_rx_valid         (st_rx_valid),
        .st_rx_startofpacket (st_rx_startofpacket),
        .st_rx_endofpacket   (st_rx_endofpacket),
        .st_rx_error         (st_rx_error),
        .beat                (beat_if.src)
    );

    rx_header_parse i_parse (
        .rx_xcvr_clk (rx_xcvr_clk),
        .rx_sync_rst (rx_sync_rst),
        .beat        (beat_if.dst),
        .pkt_done    (pkt_done),
        .pkt         (pkt)
    );

    rx_packet_classifier i_classify (
        .rx_xcvr_clk         (rx_xcvr_clk),
        .rx_sync_rst         (rx_sync_rst),
        .pkt_done            (pkt_done),
        .pkt                 (pkt),
        .local_mac           (local_mac),
        .local_ip            (local_ip),
        .local_stream_1_port (local_stream_1_port),
        .local_stream_2_port (local_stream_2_port),
        .tx_busy             (tx_busy),
        .arp_reply_valid     (arp_to_tx_valid),
        .arp_reply           (arp_reply),
        .udp_status_valid    (udp_status_valid),
        .udp_status          (udp_status),
        .select_udp_port     (select_udp_port)
    );

    assign arp_to_tx_mac     = arp_reply.mac;
    assign arp_to_tx_ip      = arp_reply.ip;
    assign udp_status_length = udp_status.length;
    assign udp_status_ip     = udp_status.ip;
    assign udp_status_mac    = udp_status.mac;

endmodule

// File: tests/tb_packets.svh
`ifndef TB_PACKETS_SVH
`define TB_PACKETS_SVH

typedef struct packed {
    eth_pkg::mac_t mac;
    eth_pkg::ip_t  ip;
    int            due;   // edge count seen by the monitor when the strobe is due
} arp_exp_t;

typedef struct packed {
    logic           sel;
    eth_pkg::port_t length;
    eth_pkg::ip_t   ip;
    eth_pkg::mac_t  mac;
    int             due;
} udp_exp_t;

logic [15:0]    lfsr_state = 16'd14089;
eth_pkg::byte_t frame [0:63];
arp_exp_t       arp_q [$];
udp_exp_t       udp_q [$];

// x^16 + x^14 + x^13 + x^11, one shift per bit taken
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[0] ^ lfsr_state[2] ^ lfsr_state[3] ^ lfsr_state[5];
    lfsr_state = {fb, lfsr_state[15:1]};
    return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[30:0], lfsr_bit()};
    return v;
endfunction

function automatic eth_pkg::mac_t rand_mac();
    logic [31:0] hi;
    hi = rand_bits(16);
    return {hi[15:0], rand_bits(32)};
endfunction

// fields go on the wire msb first
task automatic put_field(input int ofs, input int nbytes, input logic [47:0] value);
    for (int i = 0; i < nbytes; i++)
        frame[ofs + i] = value[8 * (nbytes - 1 - i) +: 8];
endtask

function automatic logic [47:0] get_field(input int ofs, input int nbytes);
    logic [47:0] v;
    v = '0;
    for (int i = 0; i < nbytes; i++)
        v = {v[39:0], frame[ofs + i]};
    return v;
endfunction

task automatic fill_random();
    for (int i = 0; i < 64; i++)
        frame[i] = eth_pkg::byte_t'(rand_bits(8));
endtask

task automatic build_udp(input eth_pkg::mac_t dst, input eth_pkg::byte_t ver_ihl,
                         input eth_pkg::ip_proto_t proto, input eth_pkg::ip_t dst_ip,
                         input eth_pkg::port_t port, input eth_pkg::port_t udp_len);
    fill_random();   // payload and the fields nobody looks at
    put_field(`RX_OFS_DST_MAC, 6, dst);
    put_field(`RX_OFS_SRC_MAC, 6, rand_mac());
    put_field(`RX_OFS_ETHERTYPE, 2, 48'(`RX_ETHERTYPE_IPV4));
    put_field(`RX_OFS_IP_VER_IHL, 1, 48'(ver_ihl));
    put_field(`RX_OFS_IP_PROTO, 1, 48'(proto));
    put_field(`RX_OFS_IP_SRC, 4, 48'(rand_bits(32)));
    put_field(`RX_OFS_IP_DST, 4, 48'(dst_ip));
    put_field(`RX_OFS_UDP_DST_PORT, 2, 48'(port));
    put_field(`RX_OFS_UDP_LEN, 2, 48'(udp_len));
endtask

task automatic build_arp(input eth_pkg::mac_t dst, input eth_pkg::port_t oper,
                         input eth_pkg::ip_t tpa);
    fill_random();
    put_field(`RX_OFS_DST_MAC, 6, dst);
    put_field(`RX_OFS_SRC_MAC, 6, rand_mac());
    put_field(`RX_OFS_ETHERTYPE, 2, 48'(`RX_ETHERTYPE_ARP));
    put_field(`RX_OFS_ARP_OPER, 2, 48'(oper));
    put_field(`RX_OFS_ARP_SPA, 4, 48'(rand_bits(32)));
    put_field(`RX_OFS_ARP_TPA, 4, 48'(tpa));
endtask

// reference model, reads the header straight from the frame bytes
task automatic model_packet(input int len, input logic err, input logic busy, input int due);
    logic [47:0] dst;
    logic [47:0] etype;
    logic [47:0] port;
    logic [47:0] ulen;
    logic [47:0] tmp;
    logic        gate;
    arp_exp_t    a;
    udp_exp_t    u;
    dst   = get_field(`RX_OFS_DST_MAC, 6);
    etype = get_field(`RX_OFS_ETHERTYPE, 2);
    port  = get_field(`RX_OFS_UDP_DST_PORT, 2);
    ulen  = get_field(`RX_OFS_UDP_LEN, 2);
    gate  = !err && (len >= `RX_MIN_FRAME_LEN)
         && ((dst == local_mac) || (dst == 48'hffff_ffff_ffff));
    if (gate && (etype == 48'(`RX_ETHERTYPE_ARP))
        && (get_field(`RX_OFS_ARP_OPER, 2) == 48'(`RX_ARP_OPER_REQUEST))
        && (get_field(`RX_OFS_ARP_TPA, 4) == 48'(local_ip)) && !busy)
    begin
        a.mac = get_field(`RX_OFS_SRC_MAC, 6);
        tmp   = get_field(`RX_OFS_ARP_SPA, 4);
        a.ip  = tmp[31:0];
        a.due = due;
        arp_q.push_back(a);
    end
    if (gate && (etype == 48'(`RX_ETHERTYPE_IPV4))
        && (get_field(`RX_OFS_IP_VER_IHL, 1) == 48'(`RX_IPV4_VER_IHL))
        && (get_field(`RX_OFS_IP_PROTO, 1) == 48'(`RX_IP_PROTO_UDP))
        && (get_field(`RX_OFS_IP_DST, 4) == 48'(local_ip))
        && ((port == 48'(local_stream_1_port)) || (port == 48'(local_stream_2_port)))
        && (ulen != 48'd0))
    begin
        u.sel    = (port == 48'(local_stream_2_port));
        u.length = ulen[15:0];
        tmp      = get_field(`RX_OFS_IP_SRC, 4);
        u.ip     = tmp[31:0];
        u.mac    = get_field(`RX_OFS_SRC_MAC, 6);
        u.due    = due;
        udp_q.push_back(u);
    end
endtask

`endif

// File: tests/tb_rx_manager.sv
`timescale 1ns/10ps
`include "rx_config.svh"

module tb_rx_manager;

    localparam int CLK_PERIOD     = 40;
    localparam int RESULT_LATENCY = 2;   // edges from the eop sample to the registered strobe
    localparam int DRAIN_CYCLES   = RESULT_LATENCY + 4;
    localparam int RANDOM_PACKETS = 200;
    localparam int TOTAL_PACKETS  = RANDOM_PACKETS + 16;
    localparam int WATCHDOG_NS    = TOTAL_PACKETS * 64 * CLK_PERIOD * 3 + 100 * CLK_PERIOD;

    logic           rx_xcvr_clk;
    logic           rx_sync_rst;
    eth_pkg::byte_t st_rx_data;
    logic           st_rx_valid;
    logic           st_rx_startofpacket;
    logic           st_rx_endofpacket;
    logic           st_rx_error;
    logic           st_rx_ready;
    eth_pkg::mac_t  local_mac;
    eth_pkg::ip_t   local_ip;
    eth_pkg::port_t local_stream_1_port;
    eth_pkg::port_t local_stream_2_port;
    logic           tx_busy;
    logic           arp_to_tx_valid;
    eth_pkg::mac_t  arp_to_tx_mac;
    eth_pkg::ip_t   arp_to_tx_ip;
    logic           udp_status_valid;
    eth_pkg::port_t udp_status_length;
    eth_pkg::ip_t   udp_status_ip;
    eth_pkg::mac_t  udp_status_mac;
    logic           select_udp_port;

    int    edge_count       = 0;
    int    error_count      = 0;
    int    test_count       = 0;
    int    tests_failed     = 0;
    int    records_seen     = 0;
    int    errors_at_start  = 0;
    int    records_at_start = 0;
    string cur_test         = "reset";

    `include "tb_packets.svh"

    rx_manager i_dut (
        .rx_xcvr_clk         (rx_xcvr_clk),
        .rx_sync_rst         (rx_sync_rst),
        .st_rx_data          (st_rx_data),
        .st_rx_valid         (st_rx_valid),
        .st_rx_startofpacket (st_rx_startofpacket),
        .st_rx_endofpacket   (st_rx_endofpacket),
        .st_rx_error         (st_rx_error),
        .st_rx_ready         (st_rx_ready),
        .local_mac           (local_mac),
        .local_ip            (local_ip),
        .local_stream_1_port (local_stream_1_port),
        .local_stream_2_port (local_stream_2_port),
        .tx_busy             (tx_busy),
        .arp_to_tx_valid     (arp_to_tx_valid),
        .arp_to_tx_mac       (arp_to_tx_mac),
        .arp_to_tx_ip        (arp_to_tx_ip),
        .udp_status_valid    (udp_status_valid),
        .udp_status_length   (udp_status_length),
        .udp_status_ip       (udp_status_ip),
        .udp_status_mac      (udp_status_mac),
        .select_udp_port     (select_udp_port)
    );

    initial
    begin
        rx_xcvr_clk = 1'b0;
        forever #(CLK_PERIOD / 2) rx_xcvr_clk = ~rx_xcvr_clk;
    end

    always @(posedge rx_xcvr_clk)
        edge_count <= edge_count + 1;

    // outputs only move on the rising edge, so look at them on the falling one
    always @(negedge rx_xcvr_clk)
    begin
        if (!rx_sync_rst)
            compare_strobes();
    end

    task automatic compare_strobes();
        arp_exp_t a;
        udp_exp_t u;
        if (arp_to_tx_valid)
        begin
            records_seen++;
            if (arp_q.size() == 0)
            begin
                $display("Failure in %s: arp reply strobe while no reply was expected", cur_test);
                error_count++;
            end
            else
            begin
                a = arp_q.pop_front();
                if (a.due != edge_count)
                begin
                    $display("** Error %s arp strobe edge: expected %0d, actual %0d",
                             cur_test, a.due, edge_count);
                    error_count++;
                end
                if ({a.mac, a.ip} !== {arp_to_tx_mac, arp_to_tx_ip})
                begin
                    $display("** Error %s arp mac/ip: expected %h, actual %h",
                             cur_test, {a.mac, a.ip}, {arp_to_tx_mac, arp_to_tx_ip});
                    error_count++;
                end
            end
        end
        if (udp_status_valid)
        begin
            records_seen++;
            if (udp_q.size() == 0)
            begin
                $display("Failure in %s: udp status strobe while no status was expected",
                         cur_test);
                error_count++;
            end
            else
            begin
                u = udp_q.pop_front();
                if (u.due != edge_count)
                begin
                    $display("** Error %s udp strobe edge: expected %0d, actual %0d",
                             cur_test, u.due, edge_count);
                    error_count++;
                end
                if ({u.sel, u.length, u.ip, u.mac} !== {select_udp_port, udp_status_length,
                                                        udp_status_ip, udp_status_mac})
                begin
                    $display("** Error %s udp sel/len/ip/mac: expected %h, actual %h",
                             cur_test, {u.sel, u.length, u.ip, u.mac},
                             {select_udp_port, udp_status_length, udp_status_ip,
                              udp_status_mac});
                    error_count++;
                end
            end
        end
    endtask

    task automatic idle_inputs();
        st_rx_valid         = 1'b0;
        st_rx_startofpacket = 1'b0;
        st_rx_endofpacket   = 1'b0;
        st_rx_error         = 1'b0;
    endtask

    // drives frame[0..len-1]; err_pos beyond the packet means no error
    task automatic send_packet(input int len, input int err_pos, input logic gaps);
        int due;
        due = 0;
        for (int i = 0; i < len; i++)
        begin
            if (gaps && (rand_bits(3) == 0))
            begin
                idle_inputs();   // one cycle with valid low
                @(negedge rx_xcvr_clk);
            end
            st_rx_data          = frame[i];
            st_rx_valid         = 1'b1;
            st_rx_startofpacket = (i == 0);
            st_rx_endofpacket   = (i == len - 1);
            st_rx_error         = (i == err_pos);
            if (i == len - 1)
                due = edge_count + 1 + RESULT_LATENCY;
            @(negedge rx_xcvr_clk);
        end
        idle_inputs();
        model_packet(len, (err_pos >= 0) && (err_pos < len), tx_busy, due);
    endtask

    task automatic build_random_packet(output int len, output int err_pos);
        logic [31:0]    pick;
        eth_pkg::mac_t  dst;
        eth_pkg::port_t port;
        eth_pkg::ip_t   ip;
        pick = rand_bits(2);
        dst  = (pick == 0) ? rand_mac() : (pick == 1) ? 48'hffff_ffff_ffff : local_mac;
        pick = rand_bits(2);
        port = (pick == 0) ? local_stream_2_port
             : (pick == 1) ? eth_pkg::port_t'(rand_bits(16)) : local_stream_1_port;
        ip   = (rand_bits(3) == 0) ? rand_bits(32) : local_ip;
        pick = rand_bits(3);
        if (pick < 5)
            build_udp(dst, (rand_bits(3) == 0) ? 8'h46 : `RX_IPV4_VER_IHL,
                      (rand_bits(3) == 0) ? 8'd6 : `RX_IP_PROTO_UDP, ip, port,
                      (rand_bits(3) == 0) ? 16'd0 : eth_pkg::port_t'(rand_bits(11)));
        else if (pick < 7)
            build_arp(dst, (rand_bits(2) == 0) ? 16'd2 : `RX_ARP_OPER_REQUEST, ip);
        else
        begin
            build_udp(dst, 8'h45, 8'd17, ip, port, 16'd64);
            put_field(`RX_OFS_ETHERTYPE, 2, 48'(rand_bits(16)));   // some other protocol
        end
        if (rand_bits(4) == 0)
            len = 20 + int'(rand_bits(4));   // runt
        else
            len = 42 + int'(rand_bits(4)) + int'(rand_bits(3));
        err_pos = (rand_bits(4) == 0) ? int'(rand_bits(6)) : -1;
    endtask

    task automatic wait_drain();
        repeat (DRAIN_CYCLES) @(negedge rx_xcvr_clk);
        if ((arp_q.size() != 0) || (udp_q.size() != 0))
        begin
            $display("Failure in %s: %0d expected records never appeared",
                     cur_test, arp_q.size() + udp_q.size());
            error_count++;
            arp_q.delete();
            udp_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        cur_test         = name;
        errors_at_start  = error_count;
        records_at_start = records_seen;
        test_count++;
    endtask

    // a negative count skips the record count check
    task automatic finish_test(input int expected_records);
        wait_drain();
        if ((expected_records >= 0) && (records_seen - records_at_start != expected_records))
        begin
            $display("** Error %s record count: expected %0d, actual %0d",
                     cur_test, expected_records, records_seen - records_at_start);
            error_count++;
        end
        if (error_count == errors_at_start)
            $display("test %s: ok, %0d records", cur_test, records_seen - records_at_start);
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, error_count - errors_at_start);
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the test sequence did not finish", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        int len;
        int err_pos;
        rx_sync_rst         = 1'b1;
        st_rx_data          = '0;
        idle_inputs();
        local_mac           = 48'h02_00_5e_10_20_30;
        local_ip            = 32'hc0a8_0a02;
        local_stream_1_port = 16'd5000;
        local_stream_2_port = 16'd5002;
        tx_busy             = 1'b0;
        repeat (16) @(negedge rx_xcvr_clk);
        rx_sync_rst = 1'b0;

        start_test("idle_after_reset");
        repeat (20)
        begin
            @(negedge rx_xcvr_clk);
            if ({arp_to_tx_valid, udp_status_valid, select_udp_port} !== 3'b000)
            begin
                $display("** Error %s arp/udp/select: expected 000, actual %b", cur_test,
                         {arp_to_tx_valid, udp_status_valid, select_udp_port});
                error_count++;
            end
            if (st_rx_ready !== 1'b1)
            begin
                $display("** Error %s st_rx_ready: expected 1, actual %b", cur_test, st_rx_ready);
                error_count++;
            end
        end
        finish_test(0);

        start_test("udp_streams");
        build_udp(local_mac, 8'h45, 8'd17, local_ip, local_stream_1_port, 16'd100);
        send_packet(60, -1, 1'b0);
        build_udp(local_mac, 8'h45, 8'd17, local_ip, local_stream_2_port, 16'd200);
        send_packet(60, -1, 1'b0);
        build_udp(48'hffff_ffff_ffff, 8'h45, 8'd17, local_ip, local_stream_1_port, 16'd28);
        send_packet(42, -1, 1'b0);
        build_udp(48'hffff_ffff_ffff, 8'h45, 8'd17, local_ip, local_stream_2_port, 16'd1472);
        send_packet(64, -1, 1'b0);
        finish_test(4);

        start_test("arp_request");
        build_arp(48'hffff_ffff_ffff, 16'd1, local_ip);
        send_packet(60, -1, 1'b0);
        finish_test(1);

        start_test("arp_tx_busy");
        tx_busy = 1'b1;
        build_arp(48'hffff_ffff_ffff, 16'd1, local_ip);
        send_packet(60, -1, 1'b0);
        finish_test(0);
        tx_busy = 1'b0;

        start_test("rejects");
        build_udp(48'h02_00_5e_10_20_31, 8'h45, 8'd17, local_ip, local_stream_1_port, 16'd64);
        send_packet(60, -1, 1'b0);
        build_udp(local_mac, 8'h45, 8'd17, local_ip ^ 32'd1, local_stream_1_port, 16'd64);
        send_packet(60, -1, 1'b0);
        build_udp(local_mac, 8'h45, 8'd17, local_ip, 16'd5001, 16'd64);
        send_packet(60, -1, 1'b0);
        build_udp(local_mac, 8'h46, 8'd17, local_ip, local_stream_1_port, 16'd64);
        send_packet(60, -1, 1'b0);
        build_udp(local_mac, 8'h45, 8'd17, local_ip, local_stream_2_port, 16'd0);
        send_packet(60, -1, 1'b0);
        build_arp(local_mac, 16'd2, local_ip);
        send_packet(60, -1, 1'b0);
        build_udp(local_mac, 8'h45, 8'd17, local_ip, local_stream_1_port, 16'd64);
        send_packet(60, 20, 1'b0);
        build_udp(local_mac, 8'h45, 8'd17, local_ip, local_stream_1_port, 16'd64);
        send_packet(30, -1, 1'b0);
        finish_test(0);

        start_test("random_stream");
        for (int n = 0; n < RANDOM_PACKETS; n++)
        begin
            build_random_packet(len, err_pos);
            send_packet(len, err_pos, 1'b1);
            if (rand_bits(2) == 0)
                repeat (rand_bits(3)) @(negedge rx_xcvr_clk);
        end
        finish_test(-1);

        $display("summary: %0d tests, %0d failed, %0d errors, %0d records checked",
                 test_count, tests_failed, error_count, records_seen);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
+incdir+tests
src/eth_pkg.sv
src/rx_pkg.sv
src/rx_beat_if.sv
src/header_field_capture.sv
src/rx_byte_tracker.sv
src/rx_header_parse.sv
src/rx_packet_classifier.sv
src/rx_manager.sv
tests/tb_rx_manager.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_rx_manager -f verilog.f \
    -o tb_rx_manager || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_rx_manager)
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED" && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
